//--- include/mem_map_macros.svh
`ifndef MEM_MAP_MACROS_SVH
`define MEM_MAP_MACROS_SVH

// Bus and word widths
`define DATA_WIDTH 16
`define ADDR_WIDTH 16
`define INSTR_WIDTH 18

// I/O window at the top of the data space
`define IO_BASE 16'hFFF8
`define PRAM_ADDR 16'hFFFF
`define KEY_FWD_ADDR 16'hFFFE
`define KEY_BACK_ADDR 16'hFFFD
`define KEY_RIGHT_ADDR 16'hFFFC
`define KEY_LEFT_ADDR 16'hFFFB
`define KEY_SHOOT_ADDR 16'hFFFA
`define KEY_RESET_ADDR 16'hFFF9
`define LCD_ADDR 16'hFFF8

// Storage sizes
`define DATA_RAM_AW 10
`define INSTR_RAM_AW 8
`define PRAM_DEPTH 8
`define NUM_KEYS 6

`endif

//--- logic/mem_map_pkg.sv
`include "mem_map_macros.svh"

package mem_map_pkg;

	////////////////////
	// Wishbone classic

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`ADDR_WIDTH-1:0] adr;
		logic [`DATA_WIDTH-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [`DATA_WIDTH-1:0] dat;
	} wb_rsp_t;

	////////////////////
	// Decode results

	typedef enum logic [1:0] {
		REG_MAIN,
		REG_PRAM,
		REG_KEY,
		REG_LCD
	} region_e;

	// Order matches key_press bits
	typedef enum logic [2:0] {
		KEY_FWD   = 3'd0,
		KEY_BACK  = 3'd1,
		KEY_RIGHT = 3'd2,
		KEY_LEFT  = 3'd3,
		KEY_SHOOT = 3'd4,
		KEY_RESET = 3'd5
	} key_e;

	// One-cycle command to the I/O devices
	typedef struct packed {
		logic wr;
		logic rd;
		region_e region;
		key_e key;
		logic [`DATA_WIDTH-1:0] wdata;
	} io_cmd_t;

	typedef enum logic {
		ST_IDLE,
		ST_ACK
	} ctrl_state_e;

endpackage

//--- logic/mem_ctrl.sv
`include "mem_map_macros.svh"

module mem_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  mem_map_pkg::wb_req_t wb_req,
	input  logic [`DATA_WIDTH-1:0] ram_rdata,
	input  logic [`DATA_WIDTH-1:0] key_rdata,
	input  logic pram_full,
	output mem_map_pkg::wb_rsp_t wb_rsp,
	output logic ram_we,
	output logic [`DATA_RAM_AW-1:0] ram_addr,
	output logic [`DATA_WIDTH-1:0] ram_wdata,
	output mem_map_pkg::io_cmd_t io_cmd
);
	import mem_map_pkg::*;

	ctrl_state_e state;
	region_e dec_region;
	region_e region_q;
	key_e dec_key;
	logic we_q;
	logic accept;

	////////////////////
	// Address decode

	always_comb begin
		dec_region = (wb_req.adr >= `IO_BASE) ? REG_KEY : REG_MAIN;
		dec_key = KEY_FWD;
		case (wb_req.adr)
			`PRAM_ADDR:      dec_region = REG_PRAM;
			`LCD_ADDR:       dec_region = REG_LCD;
			`KEY_FWD_ADDR:   dec_key = KEY_FWD;
			`KEY_BACK_ADDR:  dec_key = KEY_BACK;
			`KEY_RIGHT_ADDR: dec_key = KEY_RIGHT;
			`KEY_LEFT_ADDR:  dec_key = KEY_LEFT;
			`KEY_SHOOT_ADDR: dec_key = KEY_SHOOT;
			`KEY_RESET_ADDR: dec_key = KEY_RESET;
			default:         dec_key = KEY_FWD;
		endcase
	end

	// A strobe seen in idle is taken exactly once
	assign accept = (state == ST_IDLE) && wb_req.cyc && wb_req.stb;

	////////////////////
	// Slave FSM

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (accept) state <= ST_ACK;
				ST_ACK:  state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Remember what the ack cycle has to return
	always_ff @(posedge clk) begin
		if (accept) begin
			region_q <= dec_region;
			we_q <= wb_req.we;
		end
	end

	////////////////////
	// Device commands

	// Main RAM sees the bus directly, write gated by decode
	assign ram_we = accept && wb_req.we && (dec_region == REG_MAIN);
	assign ram_addr = wb_req.adr[`DATA_RAM_AW-1:0];
	assign ram_wdata = wb_req.dat;

	assign io_cmd.wr = accept && wb_req.we;
	assign io_cmd.rd = accept && !wb_req.we;
	assign io_cmd.region = dec_region;
	assign io_cmd.key = dec_key;
	assign io_cmd.wdata = wb_req.dat;

	////////////////////
	// Response

	always_comb begin
		wb_rsp.ack = (state == ST_ACK);
		wb_rsp.dat = '0;
		if (wb_rsp.ack && !we_q) begin
			case (region_q)
				REG_MAIN: wb_rsp.dat = ram_rdata;
				REG_PRAM: wb_rsp.dat = {{(`DATA_WIDTH-1){1'b0}}, pram_full};
				REG_KEY:  wb_rsp.dat = key_rdata;
				default:  wb_rsp.dat = '0;
			endcase
		end
	end

	// One ack per strobe, never back to back
	a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
		wb_rsp.ack |=> !wb_rsp.ack);

	a_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb));

endmodule

//--- logic/data_ram.sv
`include "mem_map_macros.svh"

module data_ram (
	input  logic clk,
	input  logic we,
	input  logic [`DATA_RAM_AW-1:0] addr,
	input  logic [`DATA_WIDTH-1:0] wdata,
	output logic [`DATA_WIDTH-1:0] rdata
);

	localparam int DEPTH = 1 << `DATA_RAM_AW;

	logic [`DATA_WIDTH-1:0] mem [DEPTH];

	////////////////////
	// Write port

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	////////////////////
	// Read port

	// Registered every cycle, old data on a same-address write
	always_ff @(posedge clk) begin
		rdata <= mem[addr];
	end

endmodule

//--- logic/instr_ram.sv
`include "mem_map_macros.svh"

module instr_ram (
	input  logic clk,
	input  logic load_we,
	input  logic [`INSTR_RAM_AW-1:0] load_addr,
	input  logic [`INSTR_WIDTH-1:0] load_data,
	input  logic [`ADDR_WIDTH-1:0] instr_addr,
	output logic [`INSTR_WIDTH-1:0] instr_data
);

	localparam int DEPTH = 1 << `INSTR_RAM_AW;

	logic [`INSTR_WIDTH-1:0] mem [DEPTH];

	// Boot loader is the only writer
	always_ff @(posedge clk) begin
		if (load_we) begin
			mem[load_addr] <= load_data;
		end
	end

	// Fetch path, upper address bits alias
	always_ff @(posedge clk) begin
		instr_data <= mem[instr_addr[`INSTR_RAM_AW-1:0]];
	end

endmodule

//--- logic/pram_queue.sv
`include "mem_map_macros.svh"

module pram_queue (
	input  logic clk,
	input  logic rst_n,
	input  mem_map_pkg::io_cmd_t io_cmd,
	input  logic pix_ready,
	output logic full,
	output logic pix_valid,
	output logic [`DATA_WIDTH-1:0] pix_data
);
	import mem_map_pkg::*;

	localparam int PW = $clog2(`PRAM_DEPTH);

	logic [`DATA_WIDTH-1:0] mem [`PRAM_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0] count;
	logic push;
	logic pop;

	// Flags straight from the fill level
	assign full = (count == (PW+1)'(`PRAM_DEPTH));
	assign pix_valid = (count != '0);
	assign pix_data = mem[rd_ptr];

	// Writes to a full queue are dropped
	assign push = io_cmd.wr && (io_cmd.region == REG_PRAM) && !full;
	assign pop = pix_valid && pix_ready;

	////////////////////
	// Storage

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= io_cmd.wdata;
		end
	end

	////////////////////
	// Pointers and count

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// A push into a full queue would carry the fill level past the depth
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		count <= (PW+1)'(`PRAM_DEPTH));

	// A pop from an empty queue would wrap the fill level to all ones
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!pix_valid |=> count != '1);

endmodule

//--- logic/io_regs.sv
`include "mem_map_macros.svh"

module io_regs (
	input  logic clk,
	input  logic rst_n,
	input  mem_map_pkg::io_cmd_t io_cmd,
	input  logic [`NUM_KEYS-1:0] key_press,
	output logic [`DATA_WIDTH-1:0] key_rdata,
	output logic [`DATA_WIDTH-1:0] lcd_data
);
	import mem_map_pkg::*;

	logic [`DATA_WIDTH-1:0] key_cnt [`NUM_KEYS];
	logic kb_reset;
	logic lcd_we;
	logic key_rd;

	////////////////////
	// Command decode

	// Any nonzero write to a key address clears the whole keyboard
	assign kb_reset = io_cmd.wr && (io_cmd.region == REG_KEY) && (io_cmd.wdata != '0);
	assign lcd_we = io_cmd.wr && (io_cmd.region == REG_LCD);
	assign key_rd = io_cmd.rd && (io_cmd.region == REG_KEY);

	////////////////////
	// Key press counters

	// Keyboard reset beats a strobe in the same cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_KEYS; i++) begin
				key_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `NUM_KEYS; i++) begin
				if (kb_reset) begin
					key_cnt[i] <= '0;
				end else if (key_press[i] && (key_cnt[i] != '1)) begin
					key_cnt[i] <= key_cnt[i] + 1'b1;
				end
			end
		end
	end

	// Captured on the read command so it lines up with ack
	always_ff @(posedge clk) begin
		if (key_rd) begin
			key_rdata <= key_cnt[io_cmd.key];
		end
	end

	////////////////////
	// LCD register

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lcd_data <= '0;
		end else if (lcd_we) begin
			lcd_data <= io_cmd.wdata;
		end
	end

endmodule

//--- logic/mem_subsys.sv
`include "mem_map_macros.svh"

module mem_subsys (
	input  logic clk,
	input  logic rst_n,
	input  mem_map_pkg::wb_req_t wb_req,
	input  logic load_we,
	input  logic [`INSTR_RAM_AW-1:0] load_addr,
	input  logic [`INSTR_WIDTH-1:0] load_data,
	input  logic [`ADDR_WIDTH-1:0] instr_addr,
	input  logic [`NUM_KEYS-1:0] key_press,
	input  logic pix_ready,
	output mem_map_pkg::wb_rsp_t wb_rsp,
	output logic [`INSTR_WIDTH-1:0] instr_data,
	output logic pix_valid,
	output logic [`DATA_WIDTH-1:0] pix_data,
	output logic [`DATA_WIDTH-1:0] lcd_data
);
	import mem_map_pkg::*;

	io_cmd_t io_cmd;
	logic ram_we;
	logic [`DATA_RAM_AW-1:0] ram_addr;
	logic [`DATA_WIDTH-1:0] ram_wdata;
	logic [`DATA_WIDTH-1:0] ram_rdata;
	logic [`DATA_WIDTH-1:0] key_rdata;
	logic pram_full;

	// Data port control
	mem_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.wb_req(wb_req),
		.ram_rdata(ram_rdata),
		.key_rdata(key_rdata),
		.pram_full(pram_full),
		.wb_rsp(wb_rsp),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.io_cmd(io_cmd)
	);

	data_ram u_data_ram (
		.clk(clk),
		.we(ram_we),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

	// Separate fetch path
	instr_ram u_instr_ram (
		.clk(clk),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data),
		.instr_addr(instr_addr),
		.instr_data(instr_data)
	);

	pram_queue u_pram (
		.clk(clk),
		.rst_n(rst_n),
		.io_cmd(io_cmd),
		.pix_ready(pix_ready),
		.full(pram_full),
		.pix_valid(pix_valid),
		.pix_data(pix_data)
	);

	io_regs u_io (
		.clk(clk),
		.rst_n(rst_n),
		.io_cmd(io_cmd),
		.key_press(key_press),
		.key_rdata(key_rdata),
		.lcd_data(lcd_data)
	);

endmodule

//--- dv/mem_subsys_tb.sv
`include "mem_map_macros.svh"

module mem_subsys_tb;
	import mem_map_pkg::*;

	localparam int N_MEM = 16;
	localparam int N_INSTR = 16;
	// Bus accesses, boot loads and fetches over the whole run
	localparam int PLANNED = 1 + 3 * N_MEM + 2 * N_INSTR + 20 + 22;

	logic clk, rst_n, load_we, pix_ready, pix_valid;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [`INSTR_RAM_AW-1:0] load_addr;
	logic [`INSTR_WIDTH-1:0] load_data, instr_data;
	logic [`NUM_KEYS-1:0] key_press;
	logic [`DATA_WIDTH-1:0] instr_addr, pix_data, lcd_data;

	// Reference state
	logic [`DATA_WIDTH-1:0] ram_model [1 << `DATA_RAM_AW];
	logic [`INSTR_WIDTH-1:0] instr_model [1 << `INSTR_RAM_AW];
	logic [`DATA_WIDTH-1:0] key_model [`NUM_KEYS];
	logic [`DATA_WIDTH-1:0] lcd_model;
	logic [`DATA_WIDTH-1:0] pix_q [$], exp_q [$];
	logic [`ADDR_WIDTH-1:0] mem_adr [N_MEM];
	int errors;

	mem_subsys u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////
	// Reference model

	function automatic logic [15:0] ref_read(input logic [15:0] adr);
		if (adr < `IO_BASE) return ram_model[adr[`DATA_RAM_AW-1:0]];
		if (adr == `PRAM_ADDR) return {15'h0, pix_q.size() == `PRAM_DEPTH};
		if (adr == `LCD_ADDR) return 16'h0;
		return key_model[3'(`KEY_FWD_ADDR - adr)];
	endfunction

	function automatic void ref_write(input logic [15:0] adr, input logic [15:0] dat);
		if (adr < `IO_BASE)
			ram_model[adr[`DATA_RAM_AW-1:0]] = dat;
		else if (adr == `PRAM_ADDR && pix_q.size() < `PRAM_DEPTH)
			pix_q.push_back(dat);
		else if (adr == `LCD_ADDR)
			lcd_model = dat;
		// Keyboard reset on any nonzero key write
		else if (adr != `PRAM_ADDR && dat != 16'h0)
			key_model = '{default: '0};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		errors++;
		$display("[ERROR] %s: got %h expected %h", name, got, want);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Failure: %s", what);
	endtask

	////////////////////
	// Bus side

	// One classic cycle, the expected response is queued before the strobe
	task automatic bus_access(input logic we, input logic [15:0] adr, input logic [15:0] dat);
		int waits;
		exp_q.push_back(we ? 16'h0 : ref_read(adr));
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		waits = 0;
		do begin
			@(negedge clk);
			waits++;
		end while (!wb_rsp.ack && waits < 16);
		assert (wb_rsp.ack) else report_failure("no ack for a bus access");
		assert (waits == 1) else report_mismatch("ack latency", waits, 1);
		wb_req = '0;
		if (we) ref_write(adr, dat);
		@(negedge clk);
		assert (!wb_rsp.ack) else report_failure("ack held for a second cycle");
	endtask

	task automatic read_keys();
		for (int k = 0; k < `NUM_KEYS; k++) begin
			bus_access(1'b0, 16'(`KEY_FWD_ADDR - k), 16'h0);
		end
	endtask

	// Each ack retires the oldest expected word
	always @(negedge clk) begin
		if (rst_n && wb_rsp.ack) begin
			assert (exp_q.size() != 0) else report_failure("ack with no access pending");
			if (exp_q.size() != 0) begin
				assert (wb_rsp.dat == exp_q[0])
					else report_mismatch("wb_rsp.dat", wb_rsp.dat, exp_q[0]);
				void'(exp_q.pop_front());
			end
		end
	end

	initial begin
		repeat (PLANNED * 200) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		void'($urandom(68));
		errors = 0;
		rst_n = 1'b0;
		wb_req = '0;
		{load_we, load_addr, load_data, instr_addr, key_press, pix_ready} = '0;
		lcd_model = '0;
		key_model = '{default: '0};
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		// Idle outputs after reset
		assert (!wb_rsp.ack) else report_mismatch("wb_rsp.ack", wb_rsp.ack, 0);
		assert (!pix_valid) else report_mismatch("pix_valid", pix_valid, 0);
		assert (lcd_data == '0) else report_mismatch("lcd_data", lcd_data, 0);
		bus_access(1'b0, `PRAM_ADDR, 16'h0);

		// Main memory, each word read back direct and through a high alias
		for (int i = 0; i < N_MEM; i++) begin
			mem_adr[i] = 16'($urandom_range(0, 32'hFFF7));
			bus_access(1'b1, mem_adr[i], 16'($urandom));
		end
		for (int i = 0; i < N_MEM; i++) begin
			bus_access(1'b0, mem_adr[i], 16'h0);
			bus_access(1'b0, {6'($urandom_range(0, 62)), mem_adr[i][9:0]}, 16'h0);
		end

		// Boot load, then fetch with junk in the upper address bits
		load_we = 1'b1;
		for (int i = 0; i < N_INSTR; i++) begin
			load_addr = 8'(i * 17);
			load_data = 18'($urandom);
			instr_model[load_addr] = load_data;
			@(negedge clk);
		end
		load_we = 1'b0;
		for (int i = 0; i < N_INSTR; i++) begin
			instr_addr = {8'($urandom), 8'(i * 17)};
			@(negedge clk);
			assert (instr_data == instr_model[8'(i * 17)])
				else report_mismatch("instr_data", instr_data, instr_model[8'(i * 17)]);
		end

		// Key strobes, a zero write, then a keyboard reset
		foreach (key_model[k]) begin
			repeat ($urandom_range(1, 12)) begin
				key_press = 6'(1 << k);
				@(negedge clk);
				key_press = '0;
				if (key_model[k] != 16'hFFFF) key_model[k] = key_model[k] + 16'h1;
				@(negedge clk);
			end
		end
		read_keys();
		bus_access(1'b1, `KEY_SHOOT_ADDR, 16'h0);
		read_keys();
		bus_access(1'b1, 16'(`KEY_FWD_ADDR - $urandom_range(0, 5)),
			16'($urandom_range(1, 65535)));
		read_keys();

		// LCD register
		bus_access(1'b1, `LCD_ADDR, 16'($urandom));
		assert (lcd_data == lcd_model) else report_mismatch("lcd_data", lcd_data, lcd_model);
		bus_access(1'b0, `LCD_ADDR, 16'h0);

		// Ten pixel words with the drain stalled, only eight fit
		repeat (10) bus_access(1'b1, `PRAM_ADDR, 16'($urandom));
		bus_access(1'b0, `PRAM_ADDR, 16'h0);
		pix_ready = 1'b1;
		while (pix_q.size() != 0) begin
			assert (pix_valid) else report_mismatch("pix_valid", pix_valid, 1);
			assert (pix_data == pix_q[0]) else report_mismatch("pix_data", pix_data, pix_q[0]);
			void'(pix_q.pop_front());
			@(negedge clk);
		end
		assert (!pix_valid) else report_mismatch("pix_valid", pix_valid, 0);
		pix_ready = 1'b0;
		bus_access(1'b0, `PRAM_ADDR, 16'h0);

		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- mem_subsys.f
+incdir+include
logic/mem_map_pkg.sv
logic/mem_ctrl.sv
logic/data_ram.sv
logic/instr_ram.sv
logic/pram_queue.sv
logic/io_regs.sv
logic/mem_subsys.sv
dv/mem_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f mem_subsys.f \
	--top-module mem_subsys_tb -o mem_subsys_sim || exit 1
out="$(./obj_dir/mem_subsys_sim)"
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1
